// File: hdl/hatchTapPkg.sv
// TAP state encoding for the pin-facing hatch logic.
// Widths of the instruction and data shift registers.
// Width of the work RAM address.

package hatchTapPkg;

    ////////////////////////////////////////////////////////////
    // TAP state machine.
    ////////////////////////////////////////////////////////////

    // State register width.
    localparam int TAP_STATE_W = 3;

    // Idle and reset state.
    localparam logic [TAP_STATE_W-1:0] ST_IDLE   = 3'b000;
    // Pick the instruction path.
    localparam logic [TAP_STATE_W-1:0] ST_ISEL   = 3'b001;
    // Pick the data path.
    localparam logic [TAP_STATE_W-1:0] ST_DSEL   = 3'b101;
    // Shifting the instruction register.
    localparam logic [TAP_STATE_W-1:0] ST_ISHIFT = 3'b100;
    // Shifting the data register.
    localparam logic [TAP_STATE_W-1:0] ST_DSHIFT = 3'b010;
    // One TCK period to run the shifted command.
    localparam logic [TAP_STATE_W-1:0] ST_UPDATE = 3'b110;

    ////////////////////////////////////////////////////////////
    // Register widths.
    ////////////////////////////////////////////////////////////

    // Instruction register, MSB out first.
    localparam int IR_W   = 8;
    // Data register, MSB out first.
    localparam int DR_W   = 16;
    // Work RAM address, 64K words.
    localparam int ADDR_W = 16;

endpackage

// File: hdl/hatchCmdPkg.sv
// Opcodes of the debug hatch command set.
// Status word layout captured into the instruction register.
// Instruction word union with opcode and status views.

package hatchCmdPkg;

    ////////////////////////////////////////////////////////////
    // Command codes.
    ////////////////////////////////////////////////////////////

    // No effect on the hatch or the MCU.
    localparam logic [7:0] CMD_NOP        = 8'h00;
    // Data register becomes the RAM address.
    localparam logic [7:0] CMD_SET_ADDR   = 8'h01;
    // Needs booted and paused.
    localparam logic [7:0] CMD_READ_RAM   = 8'h02;
    localparam logic [7:0] CMD_WRITE_RAM  = 8'h03;
    // Relays also need booted and paused.
    localparam logic [7:0] CMD_RELAY_SCAN = 8'h04;
    localparam logic [7:0] CMD_RELAY_SPI  = 8'h05;
    // Run and pause need booted only.
    localparam logic [7:0] CMD_RUN        = 8'h06;
    localparam logic [7:0] CMD_PAUSE      = 8'h07;

    ////////////////////////////////////////////////////////////
    // Instruction word.
    ////////////////////////////////////////////////////////////

    // Status as seen by the host after an instruction capture.
    // Reserved bits always read as zero.
    typedef struct packed {
        logic [hatchTapPkg::IR_W-3:0] reserved;
        logic                         paused;
        logic                         booted;
    } hatchStatusT;

    // Same register, read as a command or as captured status.
    typedef union packed {
        logic [hatchTapPkg::IR_W-1:0] opcode;
        hatchStatusT                  status;
    } hatchInstrT;

endpackage

// File: hdl/tckSampler.sv
// Pin sampler for the host JTAG lines.
// Synchronizes TCK, TMS and TDI into the core clock.
// Turns each TCK rising edge into a one-cycle strobe.

`timescale 1ns/100ps

module tckSampler (
    input  logic clk,
    input  logic rst,
    input  logic jtagTCK,
    input  logic jtagTMS,
    input  logic jtagTDI,
    output logic tckRise,
    output logic tms,
    output logic tdi
);

    // Sample chains with the newest bit at 0.
    logic [2:0] tckSync;
    logic [2:0] tmsSync;
    logic [2:0] tdiSync;

    ////////////////////////////////////////////////////////////
    // Synchronizers.
    ////////////////////////////////////////////////////////////

    // Host clock is asynchronous to the core.
    always_ff @(posedge clk) begin
        if (rst) begin
            tckSync <= '0;
            tmsSync <= '0;
            tdiSync <= '0;
            tckRise <= 1'b0;
        end else begin
            tckSync <= {tckSync[1:0], jtagTCK};
            tmsSync <= {tmsSync[1:0], jtagTMS};
            tdiSync <= {tdiSync[1:0], jtagTDI};
            // Edge flop, high for one cycle per TCK rise.
            tckRise <= tckSync[1] & ~tckSync[2];
        end
    end

    // TMS and TDI leave as deep as the rise strobe.
    // Both were sampled together with the new TCK level.
    assign tms = tmsSync[2];
    assign tdi = tdiSync[2];

endmodule

// File: hdl/hatchTap.sv
// TAP state machine of the debug hatch.
// Instruction and data shift registers with status capture.
// Registered TDO drive and the execute strobe.

`timescale 1ns/100ps

module hatchTap (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tckRise,
    input  logic                            tms,
    input  logic                            tdi,
    input  logic                            isBooted,
    input  logic                            isPaused,
    input  logic                            rdValid,
    input  logic [hatchTapPkg::DR_W-1:0]    rdData,
    output logic                            jtagTDO,
    output logic                            execStb,
    output hatchCmdPkg::hatchInstrT         instr,
    output logic [hatchTapPkg::DR_W-1:0]    dataReg
);

    // State register.
    logic [hatchTapPkg::TAP_STATE_W-1:0] stateQ;
    logic [hatchTapPkg::TAP_STATE_W-1:0] stateD;

    // Shift registers.
    hatchCmdPkg::hatchInstrT             irQ;
    hatchCmdPkg::hatchInstrT             irD;
    logic [hatchTapPkg::DR_W-1:0]        drQ;
    logic [hatchTapPkg::DR_W-1:0]        drD;

    // Decoded moves for this TCK rise.
    logic iShiftStep;
    logic dShiftStep;
    logic getStatus;
    logic enterUpdate;

    ////////////////////////////////////////////////////////////
    // Next state.
    ////////////////////////////////////////////////////////////

    always_comb begin
        stateD = stateQ;
        // Moves only on a TCK rise.
        if (tckRise) begin
            case (stateQ)
                hatchTapPkg::ST_IDLE:
                    stateD = tms ? hatchTapPkg::ST_IDLE : hatchTapPkg::ST_ISEL;
                hatchTapPkg::ST_ISEL:
                    stateD = tms ? hatchTapPkg::ST_DSEL : hatchTapPkg::ST_ISHIFT;
                hatchTapPkg::ST_DSEL:
                    stateD = tms ? hatchTapPkg::ST_IDLE : hatchTapPkg::ST_DSHIFT;
                hatchTapPkg::ST_ISHIFT:
                    stateD = tms ? hatchTapPkg::ST_UPDATE : hatchTapPkg::ST_ISHIFT;
                hatchTapPkg::ST_DSHIFT:
                    stateD = tms ? hatchTapPkg::ST_IDLE : hatchTapPkg::ST_DSHIFT;
                // UPDATE always falls back to idle.
                default:
                    stateD = hatchTapPkg::ST_IDLE;
            endcase
        end
    end

    // Every rise in a shift state shifts, including the exiting one.
    assign iShiftStep  = tckRise && (stateQ == hatchTapPkg::ST_ISHIFT);
    assign dShiftStep  = tckRise && (stateQ == hatchTapPkg::ST_DSHIFT);
    // Leaving I-SEL towards I-SHIFT captures status.
    assign getStatus   = tckRise && (stateQ == hatchTapPkg::ST_ISEL) && !tms;
    assign enterUpdate = iShiftStep && tms;

    ////////////////////////////////////////////////////////////
    // Shift registers.
    ////////////////////////////////////////////////////////////

    always_comb begin
        irD = irQ;
        if (getStatus) begin
            // Status view, reserved bits cleared.
            irD.status.reserved = '0;
            irD.status.paused   = isPaused;
            irD.status.booted   = isBooted;
        end else if (iShiftStep) begin
            irD.opcode = {irQ.opcode[hatchTapPkg::IR_W-2:0], tdi};
        end
    end

    always_comb begin
        drD = drQ;
        // RAM read data lands here for the next data shift.
        if (rdValid) begin
            drD = rdData;
        end else if (dShiftStep) begin
            drD = {drQ[hatchTapPkg::DR_W-2:0], tdi};
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers and TDO.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            stateQ  <= hatchTapPkg::ST_IDLE;
            irQ     <= '0;
            drQ     <= '0;
            jtagTDO <= 1'b0;
            execStb <= 1'b0;
        end else begin
            stateQ  <= stateD;
            irQ     <= irD;
            drQ     <= drD;
            // Taken from next values, so TDO settles with the state.
            jtagTDO <= (stateD == hatchTapPkg::ST_DSHIFT) ?
                       drD[hatchTapPkg::DR_W-1] : irD.opcode[hatchTapPkg::IR_W-1];
            // One pulse on entry to UPDATE.
            execStb <= enterUpdate;
        end
    end

    assign instr   = irQ;
    assign dataReg = drQ;

endmodule

// File: hdl/hatchCommand.sv
// Command executor of the debug hatch.
// Decodes the instruction on execute and gates it by MCU status.
// Holds the RAM address, relay enables and pause request.

`timescale 1ns/100ps

module hatchCommand (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            execStb,
    input  logic                            isBooted,
    input  logic                            isPaused,
    input  hatchCmdPkg::hatchInstrT         instr,
    input  logic [hatchTapPkg::DR_W-1:0]    dataReg,
    output logic                            ramRdStb,
    output logic                            ramWrStb,
    output logic                            enScanRelay,
    output logic                            enSPIRelay,
    output logic                            enPaused,
    output logic [hatchTapPkg::ADDR_W-1:0]  ramAddr,
    output logic [hatchTapPkg::DR_W-1:0]    ramWrData
);

    // Opcode view of the instruction word.
    logic [hatchTapPkg::IR_W-1:0] opcode;

    // Host owns the MCU only when booted and paused.
    logic inControl;

    // One-hot decode.
    logic isSetAddr;
    logic isRead;
    logic isWrite;
    logic isScan;
    logic isSpi;
    logic isRun;
    logic isPause;

    ////////////////////////////////////////////////////////////
    // Decode.
    ////////////////////////////////////////////////////////////

    assign opcode    = instr.opcode;
    assign inControl = isBooted & isPaused;

    // Codes above PAUSE decode to nothing.
    assign isSetAddr = (opcode == hatchCmdPkg::CMD_SET_ADDR);
    assign isRead    = (opcode == hatchCmdPkg::CMD_READ_RAM);
    assign isWrite   = (opcode == hatchCmdPkg::CMD_WRITE_RAM);
    assign isScan    = (opcode == hatchCmdPkg::CMD_RELAY_SCAN);
    assign isSpi     = (opcode == hatchCmdPkg::CMD_RELAY_SPI);
    assign isRun     = (opcode == hatchCmdPkg::CMD_RUN);
    assign isPause   = (opcode == hatchCmdPkg::CMD_PAUSE);

    ////////////////////////////////////////////////////////////
    // Execute.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ramRdStb    <= 1'b0;
            ramWrStb    <= 1'b0;
            ramAddr     <= '0;
            enScanRelay <= 1'b0;
            enSPIRelay  <= 1'b0;
            enPaused    <= 1'b0;
        end else begin
            // RAM strobes last one cycle.
            ramRdStb <= execStb && isRead && inControl;
            ramWrStb <= execStb && isWrite && inControl;
            if (execStb) begin
                // Address load needs no MCU state.
                if (isSetAddr) begin
                    ramAddr <= dataReg;
                end
                // Any executed command rewrites both relays.
                enScanRelay <= isScan && inControl;
                enSPIRelay  <= isSpi && inControl;
                // Run and pause act on a booted MCU only.
                if (isBooted && isRun) begin
                    enPaused <= 1'b0;
                end else if (isBooted && isPause) begin
                    enPaused <= 1'b1;
                end
            end
        end
    end

    // Write data comes straight from the shifted word.
    assign ramWrData = dataReg;

endmodule

// File: hdl/hatchRam.sv
// Work RAM of the debug hatch, 64K words of 16 bits.
// Single port, registered read with a valid pulse.

`timescale 1ns/100ps

module hatchRam (
    input  logic                            clk,
    input  logic                            rdStb,
    input  logic                            wrStb,
    input  logic [hatchTapPkg::ADDR_W-1:0]  addr,
    input  logic [hatchTapPkg::DR_W-1:0]    wrData,
    output logic [hatchTapPkg::DR_W-1:0]    rdData,
    output logic                            rdValid
);

    // Storage array.
    logic [hatchTapPkg::DR_W-1:0] mem [0:(2**hatchTapPkg::ADDR_W)-1];

    // Write and registered read.
    always_ff @(posedge clk) begin
        if (wrStb) begin
            mem[addr] <= wrData;
        end
        if (rdStb) begin
            rdData <= mem[addr];
        end
    end

    // Valid follows the strobe by one cycle.
    // Idle strobe clears it again.
    always_ff @(posedge clk) begin
        rdValid <= rdStb;
    end

endmodule

// File: hdl/debugHatch.sv
// Top level of the debug hatch.
// Pin sampler, TAP, command executor and work RAM.

`timescale 1ns/100ps

module debugHatch (
    input  logic clk,
    input  logic rst,
    input  logic jtagTCK,
    input  logic jtagTMS,
    input  logic jtagTDI,
    input  logic isBooted,
    input  logic isPaused,
    output logic jtagTDO,
    output logic enScanRelay,
    output logic enSPIRelay,
    output logic enPaused
);

    // Sampled pins.
    logic tckRise;
    logic tms;
    logic tdi;

    // TAP to executor.
    logic                           execStb;
    hatchCmdPkg::hatchInstrT        instr;
    logic [hatchTapPkg::DR_W-1:0]   dataReg;

    // Executor to RAM and back.
    logic                           ramRdStb;
    logic                           ramWrStb;
    logic [hatchTapPkg::ADDR_W-1:0] ramAddr;
    logic [hatchTapPkg::DR_W-1:0]   ramWrData;
    logic [hatchTapPkg::DR_W-1:0]   rdData;
    logic                           rdValid;

    ////////////////////////////////////////////////////////////
    // Instances.
    ////////////////////////////////////////////////////////////

    tckSampler sampler_i (
        .clk     (clk),
        .rst     (rst),
        .jtagTCK (jtagTCK),
        .jtagTMS (jtagTMS),
        .jtagTDI (jtagTDI),
        .tckRise (tckRise),
        .tms     (tms),
        .tdi     (tdi)
    );

    hatchTap tap_i (
        .clk      (clk),
        .rst      (rst),
        .tckRise  (tckRise),
        .tms      (tms),
        .tdi      (tdi),
        .isBooted (isBooted),
        .isPaused (isPaused),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .jtagTDO  (jtagTDO),
        .execStb  (execStb),
        .instr    (instr),
        .dataReg  (dataReg)
    );

    hatchCommand command_i (
        .clk         (clk),
        .rst         (rst),
        .execStb     (execStb),
        .isBooted    (isBooted),
        .isPaused    (isPaused),
        .instr       (instr),
        .dataReg     (dataReg),
        .ramRdStb    (ramRdStb),
        .ramWrStb    (ramWrStb),
        .enScanRelay (enScanRelay),
        .enSPIRelay  (enSPIRelay),
        .enPaused    (enPaused),
        .ramAddr     (ramAddr),
        .ramWrData   (ramWrData)
    );

    hatchRam ram_i (
        .clk     (clk),
        .rdStb   (ramRdStb),
        .wrStb   (ramWrStb),
        .addr    (ramAddr),
        .wrData  (ramWrData),
        .rdData  (rdData),
        .rdValid (rdValid)
    );

endmodule

// File: sim/hatchHostTasks.svh
// Host-side JTAG tasks for a TCK period, both register shifts and idle.
// Reference model of the work RAM and the hatch control state.

// Model of RAM contents and control levels.
logic [15:0] ramModel [logic [15:0]];
logic [15:0] modelAddr;
logic [15:0] modelData;
logic        modelScan;
logic        modelSpi;
logic        modelPaused;

// One TCK period. TDO is sampled just before the rise.
task automatic tckCycle(input logic tmsVal, input logic tdiVal, output logic tdoVal);
    @(posedge clk);
    #1;
    jtagTCK = 1'b0;
    jtagTMS = tmsVal;
    jtagTDI = tdiVal;
    repeat (TCK_HALF) @(posedge clk);
    #1;
    tdoVal  = jtagTDO;
    jtagTCK = 1'b1;
    repeat (TCK_HALF - 1) @(posedge clk);
endtask

// IDLE, I-SEL, I-SHIFT with status capture, then UPDATE and IDLE.
task automatic shiftInstr(input logic [7:0] value, output logic [7:0] captured);
    logic bitOut;
    int   i;
    captured = '0;
    tckCycle(1'b0, 1'b0, bitOut);
    tckCycle(1'b0, 1'b0, bitOut);
    // MSB first, TMS high on the last bit enters UPDATE.
    for (i = hatchTapPkg::IR_W - 1; i >= 0; i--) begin
        tckCycle(i == 0, value[i], bitOut);
        captured = {captured[6:0], bitOut};
    end
    tckCycle(1'b1, 1'b0, bitOut);
endtask

// IDLE, I-SEL, D-SEL, D-SHIFT, and back to IDLE on the last bit.
task automatic shiftData(input logic [15:0] value, output logic [15:0] captured);
    logic bitOut;
    int   i;
    captured = '0;
    tckCycle(1'b0, 1'b0, bitOut);
    tckCycle(1'b1, 1'b0, bitOut);
    tckCycle(1'b0, 1'b0, bitOut);
    for (i = hatchTapPkg::DR_W - 1; i >= 0; i--) begin
        tckCycle(i == 0, value[i], bitOut);
        captured = {captured[14:0], bitOut};
    end
endtask

// Five rises with TMS high reach IDLE from any select state.
task automatic gotoIdle();
    logic bitOut;
    repeat (5) tckCycle(1'b1, 1'b0, bitOut);
endtask

// Effect of one executed instruction on the model.
task automatic modelExec(input logic [7:0] op);
    logic inControl;
    inControl = isBooted && isPaused;
    if (op == hatchCmdPkg::CMD_SET_ADDR) begin
        modelAddr = modelData;
    end
    if (op == hatchCmdPkg::CMD_READ_RAM && inControl) begin
        modelData = ramModel[modelAddr];
    end
    if (op == hatchCmdPkg::CMD_WRITE_RAM && inControl) begin
        ramModel[modelAddr] = modelData;
    end
    // Relays are rewritten by every instruction.
    modelScan = (op == hatchCmdPkg::CMD_RELAY_SCAN) && inControl;
    modelSpi  = (op == hatchCmdPkg::CMD_RELAY_SPI) && inControl;
    // Pause control needs a booted MCU only.
    if (isBooted && op == hatchCmdPkg::CMD_RUN) begin
        modelPaused = 1'b0;
    end
    if (isBooted && op == hatchCmdPkg::CMD_PAUSE) begin
        modelPaused = 1'b1;
    end
endtask

// File: sim/debugHatchTb.sv
// Testbench for the debug hatch top level.
// Clock, reset, watchdog and a seeded random scenario loop.
// Checks against the host model and a closing report.

`timescale 1ns/100ps

module debugHatchTb;

    // Clock period, and TCK phase length in clk cycles.
    localparam int CLK_NS       = 8;
    localparam int TCK_HALF     = 8;
    // Scenario count, and an upper bound of TCK periods per scenario.
    localparam int NUM_SCEN     = 60;
    localparam int TCK_PER_SCEN = 240;
    localparam int WATCHDOG_NS  = (NUM_SCEN + 1) * TCK_PER_SCEN * 16 * CLK_NS + 20000;

    logic clk;
    logic rst;
    logic jtagTCK;
    logic jtagTMS;
    logic jtagTDI;
    logic isBooted;
    logic isPaused;
    logic jtagTDO;
    logic enScanRelay;
    logic enSPIRelay;
    logic enPaused;

    int          errCount;
    int          checkCount;
    // Addresses that hold a known word.
    logic [15:0] usedAddrs [$];

    `include "hatchHostTasks.svh"

    debugHatch dut_i (
        .clk         (clk),
        .rst         (rst),
        .jtagTCK     (jtagTCK),
        .jtagTMS     (jtagTMS),
        .jtagTDI     (jtagTDI),
        .isBooted    (isBooted),
        .isPaused    (isPaused),
        .jtagTDO     (jtagTDO),
        .enScanRelay (enScanRelay),
        .enSPIRelay  (enSPIRelay),
        .enPaused    (enPaused)
    );

    ////////////////////////////////////////////////////////////
    // Clock and watchdog.
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the scenarios finished.");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Checks and host operations.
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        checkCount++;
        assert (actual === expected)
        else begin
            errCount++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareLevels(input string name);
        checkValue({name, " scan relay"}, 16'(modelScan), 16'(enScanRelay));
        checkValue({name, " spi relay"}, 16'(modelSpi), 16'(enSPIRelay));
        checkValue({name, " paused"}, 16'(modelPaused), 16'(enPaused));
    endtask

    // MCU levels change 1 ns after a clk edge.
    task automatic setMcu(input logic booted, input logic paused);
        @(posedge clk);
        #1;
        isBooted = booted;
        isPaused = paused;
    endtask

    // Every instruction shift returns the status byte.
    task automatic runCommand(input logic [7:0] op);
        logic [7:0] captured;
        shiftInstr(op, captured);
        checkValue("status capture", {14'h0, isPaused, isBooted}, {8'h00, captured});
        modelExec(op);
    endtask

    // Data shift that checks the echo of the previous data register.
    task automatic loadData(input string name, input logic [15:0] value);
        logic [15:0] captured;
        shiftData(value, captured);
        checkValue(name, modelData, captured);
        modelData = value;
    endtask

    task automatic writeWord(input logic [15:0] addr, input logic [15:0] value);
        loadData("write addr echo", addr);
        runCommand(hatchCmdPkg::CMD_SET_ADDR);
        loadData("write data echo", value);
        runCommand(hatchCmdPkg::CMD_WRITE_RAM);
    endtask

    // Read data shows up in the echo of the next shift.
    task automatic readWord(input logic [15:0] addr);
        loadData("read addr echo", addr);
        runCommand(hatchCmdPkg::CMD_SET_ADDR);
        runCommand(hatchCmdPkg::CMD_READ_RAM);
        loadData("read data", 16'($urandom));
    endtask

    ////////////////////////////////////////////////////////////
    // Scenarios.
    ////////////////////////////////////////////////////////////

    // Allowed write and read-back at a new or reused address.
    task automatic writeReadBack();
        logic [15:0] addr;
        int          idx;
        setMcu(1'b1, 1'b1);
        if (usedAddrs.size() > 0 && $urandom % 2 == 0) begin
            idx  = int'($urandom % usedAddrs.size());
            addr = usedAddrs[idx];
        end else begin
            addr = 16'($urandom);
            usedAddrs.push_back(addr);
        end
        writeWord(addr, 16'($urandom));
        readWord(addr);
    endtask

    // Write and read with the MCU not under host control.
    task automatic blockedAccess();
        logic [15:0] addr;
        logic [1:0]  mcu;
        setMcu(1'b1, 1'b1);
        addr = 16'($urandom);
        usedAddrs.push_back(addr);
        writeWord(addr, 16'($urandom));
        // Values 0 to 2 never have booted and paused together.
        mcu = 2'($urandom % 3);
        setMcu(mcu[1], mcu[0]);
        writeWord(addr, 16'($urandom));
        runCommand(hatchCmdPkg::CMD_READ_RAM);
        loadData("blocked read echo", 16'($urandom));
        setMcu(1'b1, 1'b1);
        readWord(addr);
    endtask

    // Relay and pause commands under random MCU levels.
    task automatic controlCommands();
        logic [1:0] mcu;
        logic [7:0] op;
        repeat (3) begin
            mcu = 2'($urandom);
            setMcu(mcu[1], mcu[0]);
            op = 8'($urandom % 8);
            // Reads stay in the RAM scenarios.
            if (op == hatchCmdPkg::CMD_READ_RAM) begin
                op = hatchCmdPkg::CMD_NOP;
            end
            runCommand(op);
            compareLevels("control");
        end
    endtask

    // TMS walks, gotoIdle and undefined opcodes.
    task automatic tapNoise();
        logic       bitOut;
        logic [1:0] mcu;
        int         steps;
        int         i;
        mcu = 2'($urandom);
        setMcu(mcu[1], mcu[0]);
        steps = 1 + int'($urandom % 4);
        for (i = 0; i < steps; i++) begin
            if ($urandom % 2 == 0) begin
                tckCycle(1'b1, 1'($urandom), bitOut);
            end else begin
                // Through I-SEL and D-SEL back to IDLE.
                tckCycle(1'b0, 1'($urandom), bitOut);
                tckCycle(1'b1, 1'($urandom), bitOut);
                tckCycle(1'b1, 1'($urandom), bitOut);
            end
        end
        tckCycle(1'b0, 1'b0, bitOut);
        gotoIdle();
        runCommand(8'(8 + $urandom % 248));
        loadData("noise echo", 16'($urandom));
        compareLevels("noise");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////

    initial begin
        int scen;
        int i;
        void'($urandom(18720));
        rst         = 1'b1;
        jtagTCK     = 1'b0;
        jtagTMS     = 1'b1;
        jtagTDI     = 1'b0;
        isBooted    = 1'b0;
        isPaused    = 1'b0;
        errCount    = 0;
        checkCount  = 0;
        modelAddr   = '0;
        modelData   = '0;
        modelScan   = 1'b0;
        modelSpi    = 1'b0;
        modelPaused = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // Reset levels, then status capture for all MCU levels.
        compareLevels("reset");
        checkValue("reset tdo", 16'h0000, 16'(jtagTDO));
        for (i = 0; i < 4; i++) begin
            setMcu(i[1], i[0]);
            runCommand(hatchCmdPkg::CMD_NOP);
        end
        loadData("reset data echo", 16'($urandom));
        for (scen = 0; scen < NUM_SCEN; scen++) begin
            case ($urandom % 4)
                0:       writeReadBack();
                1:       blockedAccess();
                2:       controlCommands();
                default: tapNoise();
            endcase
            compareLevels("scenario end");
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: debugHatch.f
+incdir+sim
hdl/hatchTapPkg.sv
hdl/hatchCmdPkg.sv
hdl/tckSampler.sv
hdl/hatchTap.sv
hdl/hatchCommand.sv
hdl/hatchRam.sv
hdl/debugHatch.sv
sim/debugHatchTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the debug hatch testbench with Verilator and runs it.
# The log decides pass or fail.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f debugHatch.f \
    --top-module debugHatchTb -Mdir "$BUILD_DIR" -o debugHatchSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/debugHatchSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG_FILE"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG_FILE"; then
    echo "Simulation log holds no final result"
    exit 1
fi
exit 0
